// File: core_cfg_pkg.sv
// --------------------------------------------------
// Core configuration
// Word, address and stack sizes of the stack core
// --------------------------------------------------

package core_cfg_pkg;

	// Datapath
	localparam int NUBITS = 16;

	// Memory address widths
	localparam int MINSTW = 9;
	localparam int MDATAW = 9;

	// IO port address widths
	localparam int NBIOIN = 2;
	localparam int NBIOOU = 2;

	// Stack depths
	localparam int SDEPTH = 8;
	localparam int DDEPTH = 8;

	typedef logic signed [NUBITS-1:0] data_t;
	typedef logic        [MINSTW-1:0] iaddr_t;
	typedef logic        [MDATAW-1:0] daddr_t;
	typedef logic        [NBIOIN-1:0] io_in_addr_t;
	typedef logic        [NBIOOU-1:0] io_out_addr_t;

endpackage

// File: isa_pkg.sv
// --------------------------------------------------
// Instruction set
// Opcode map, instruction fields and ALU operations
// --------------------------------------------------

package isa_pkg;

	localparam int NBOPCO = 7;
	localparam int NBOPER = 9;
	localparam int NBINST = NBOPCO + NBOPER;

	// Opcode in the upper bits, operand in the lower bits
	typedef logic [NBOPCO-1:0] opcode_t;
	typedef logic [NBOPER-1:0] operand_t;
	typedef logic [NBINST-1:0] instr_t;

	// Opcode map, unlisted codes behave as NOP
	localparam opcode_t OP_NOP  = 7'd0;
	localparam opcode_t OP_LOD  = 7'd1;
	localparam opcode_t OP_SET  = 7'd2;
	localparam opcode_t OP_PSH  = 7'd3;
	localparam opcode_t OP_POP  = 7'd4;
	localparam opcode_t OP_INN  = 7'd5;
	localparam opcode_t OP_OUT  = 7'd6;
	localparam opcode_t OP_ADD  = 7'd7;
	localparam opcode_t OP_SUB  = 7'd8;
	localparam opcode_t OP_AND  = 7'd9;
	localparam opcode_t OP_XOR  = 7'd10;
	localparam opcode_t OP_SADD = 7'd11;
	localparam opcode_t OP_JMP  = 7'd15;
	localparam opcode_t OP_JIZ  = 7'd16;
	localparam opcode_t OP_CAL  = 7'd17;
	localparam opcode_t OP_RET  = 7'd18;

	// Execute stage operation
	typedef enum logic [3:0] {
		ALU_PASS,
		ALU_MEM,
		ALU_STK,
		ALU_IO,
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_XOR,
		ALU_SADD
	} alu_op_t;

endpackage

// File: lifo.sv
// --------------------------------------------------
// LIFO stack
// Generic stack for data words or return addresses
// --------------------------------------------------

`timescale 1ns/1ps

module lifo #(
	parameter int  DEPTH = 8,
	parameter type T     = logic [7:0]
) (
	input  logic clk,
	input  logic rst,
	input  logic push,
	input  logic pop,
	input  T     din,
	output T     top
);

	localparam int PW = (DEPTH > 1) ? $clog2(DEPTH) : 1;

	T              mem [DEPTH];
	logic [PW-1:0] ptr;

	// Pointer marks the next free slot
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			ptr <= '0;
		end else if (push) begin
			ptr <= ptr + 1'b1;
		end else if (pop) begin
			ptr <= ptr - 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (push) begin
			mem[ptr] <= din;
		end
	end

	// Last pushed entry, no overflow or underflow guard
	assign top = mem[ptr - 1'b1];

endmodule

// File: instr_fetch.sv
// --------------------------------------------------
// Instruction fetch
// Program counter, jump and call/return selection
// --------------------------------------------------

`timescale 1ns/1ps

module instr_fetch
	import core_cfg_pkg::*, isa_pkg::*;
(
	input  logic     clk,
	input  logic     rst,
	input  instr_t   instr,
	input  logic     acc_zero,
	output iaddr_t   instr_addr,
	output opcode_t  opcode,
	output operand_t operand
);

	iaddr_t pc;
	iaddr_t pc_inc;
	iaddr_t pc_next;
	iaddr_t ret_addr;
	logic   is_jmp;
	logic   is_cal;
	logic   is_ret;

	// Instruction fields
	assign opcode  = instr[NBINST-1 -: NBOPCO];
	assign operand = instr[NBOPER-1:0];

	// JIZ sees the result of the instruction now in execute
	assign is_jmp = (opcode == OP_JMP) || ((opcode == OP_JIZ) && acc_zero);
	assign is_cal = (opcode == OP_CAL);
	assign is_ret = (opcode == OP_RET);

	assign pc_inc = pc + 1'b1;

	always_comb begin
		if (is_jmp || is_cal) begin
			pc_next = iaddr_t'(operand);
		end else if (is_ret) begin
			pc_next = ret_addr;
		end else begin
			pc_next = pc_inc;
		end
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			pc <= '0;
		end else begin
			pc <= pc_next;
		end
	end

	assign instr_addr = pc;

	// Return stack holds the address after the call
	lifo #(.DEPTH(SDEPTH), .T(iaddr_t)) ret_stack_i (
		.clk (clk),
		.rst (rst),
		.push(is_cal),
		.pop (is_ret),
		.din (pc_inc),
		.top (ret_addr)
	);

endmodule

// File: instr_dec.sv
// --------------------------------------------------
// Instruction decoder
// Maps opcodes to ALU operations and strobes
// --------------------------------------------------

`timescale 1ns/1ps

module instr_dec
	import core_cfg_pkg::*, isa_pkg::*;
(
	input  logic        clk,
	input  logic        rst,
	input  opcode_t     opcode,
	input  operand_t    operand,
	output daddr_t      mem_addr_rd,
	output logic        req_in,
	output io_in_addr_t addr_in,
	output alu_op_t     alu_op,
	output logic        mem_wr,
	output logic        out_en,
	output logic        dsp_push,
	output logic        dsp_pop,
	output operand_t    ex_operand
);

	alu_op_t dec_alu;
	logic    dec_wr;
	logic    dec_out;
	logic    dec_push;
	logic    dec_pop;

	// Fetch cycle requests, read data arrives in execute
	assign mem_addr_rd = daddr_t'(operand);
	assign addr_in     = operand[NBIOIN-1:0];
	assign req_in      = (opcode == OP_INN) && !rst;

	always_comb begin
		dec_alu  = ALU_PASS;
		dec_wr   = 1'b0;
		dec_out  = 1'b0;
		dec_push = 1'b0;
		dec_pop  = 1'b0;
		case (opcode)
			OP_LOD:  dec_alu = ALU_MEM;
			OP_SET:  dec_wr = 1'b1;
			OP_PSH:  dec_push = 1'b1;
			OP_POP: begin
				dec_alu = ALU_STK;
				dec_pop = 1'b1;
			end
			OP_INN:  dec_alu = ALU_IO;
			OP_OUT:  dec_out = 1'b1;
			OP_ADD:  dec_alu = ALU_ADD;
			OP_SUB:  dec_alu = ALU_SUB;
			OP_AND:  dec_alu = ALU_AND;
			OP_XOR:  dec_alu = ALU_XOR;
			OP_SADD: begin
				dec_alu = ALU_SADD;
				dec_pop = 1'b1;
			end
			// Jumps and unknown codes leave the accumulator alone
			default: ;
		endcase
	end

	// Decode register, a NOP while in reset
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			alu_op     <= ALU_PASS;
			mem_wr     <= 1'b0;
			out_en     <= 1'b0;
			dsp_push   <= 1'b0;
			dsp_pop    <= 1'b0;
			ex_operand <= '0;
		end else begin
			alu_op     <= dec_alu;
			mem_wr     <= dec_wr;
			out_en     <= dec_out;
			dsp_push   <= dec_push;
			dsp_pop    <= dec_pop;
			ex_operand <= operand;
		end
	end

endmodule

// File: exec_unit.sv
// --------------------------------------------------
// Execute unit
// Operand select, ALU and accumulator
// --------------------------------------------------

`timescale 1ns/1ps

module exec_unit
	import core_cfg_pkg::*, isa_pkg::*;
(
	input  logic    clk,
	input  logic    rst,
	input  alu_op_t alu_op,
	input  data_t   mem_data_rd,
	input  data_t   io_in,
	input  data_t   stk_top,
	output data_t   result,
	output data_t   acc,
	output logic    acc_zero
);

	data_t io_r;

	// Input port value sampled at the end of the fetch cycle
	always_ff @(posedge clk) begin
		io_r <= io_in;
	end

	always_comb begin
		case (alu_op)
			ALU_MEM:  result = mem_data_rd;
			ALU_STK:  result = stk_top;
			ALU_IO:   result = io_r;
			ALU_ADD:  result = acc + mem_data_rd;
			ALU_SUB:  result = acc - mem_data_rd;
			ALU_AND:  result = acc & mem_data_rd;
			ALU_XOR:  result = acc ^ mem_data_rd;
			ALU_SADD: result = acc + stk_top;
			default:  result = acc;
		endcase
	end

	//--------------------------------------------------
	// Accumulator
	//--------------------------------------------------

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			acc <= '0;
		end else begin
			acc <= result;
		end
	end

	// Zero flag goes straight back to fetch for JIZ
	assign acc_zero = (result == '0);

endmodule

// File: stack_core.sv
// --------------------------------------------------
// Stack core top level
// Two-stage accumulator core with data stack and IO
// --------------------------------------------------

`timescale 1ns/1ps

module stack_core
	import core_cfg_pkg::*, isa_pkg::*;
(
	input  logic         clk,
	input  logic         rst,
	input  instr_t       instr,
	output iaddr_t       instr_addr,
	output logic         mem_wr,
	output daddr_t       mem_addr_rd,
	output daddr_t       mem_addr_wr,
	output data_t        mem_data_wr,
	input  data_t        mem_data_rd,
	input  data_t        io_in,
	output logic         req_in,
	output io_in_addr_t  addr_in,
	output logic         out_en,
	output io_out_addr_t addr_out
);

	opcode_t  if_opcode;
	operand_t if_operand;
	operand_t ex_operand;
	alu_op_t  ex_alu_op;
	logic     dsp_push;
	logic     dsp_pop;
	logic     acc_zero;
	data_t    acc;
	data_t    stk_top;

	//--------------------------------------------------
	// Fetch and decode
	//--------------------------------------------------

	instr_fetch instr_fetch_i (
		.clk       (clk),
		.rst       (rst),
		.instr     (instr),
		.acc_zero  (acc_zero),
		.instr_addr(instr_addr),
		.opcode    (if_opcode),
		.operand   (if_operand)
	);

	instr_dec instr_dec_i (
		.clk        (clk),
		.rst        (rst),
		.opcode     (if_opcode),
		.operand    (if_operand),
		.mem_addr_rd(mem_addr_rd),
		.req_in     (req_in),
		.addr_in    (addr_in),
		.alu_op     (ex_alu_op),
		.mem_wr     (mem_wr),
		.out_en     (out_en),
		.dsp_push   (dsp_push),
		.dsp_pop    (dsp_pop),
		.ex_operand (ex_operand)
	);

	//--------------------------------------------------
	// Execute
	//--------------------------------------------------

	exec_unit exec_unit_i (
		.clk        (clk),
		.rst        (rst),
		.alu_op     (ex_alu_op),
		.mem_data_rd(mem_data_rd),
		.io_in      (io_in),
		.stk_top    (stk_top),
		.result     (),
		.acc        (acc),
		.acc_zero   (acc_zero)
	);

	lifo #(.DEPTH(DDEPTH), .T(data_t)) data_stack_i (
		.clk (clk),
		.rst (rst),
		.push(dsp_push),
		.pop (dsp_pop),
		.din (acc),
		.top (stk_top)
	);

	// SET and OUT both send the accumulator
	assign mem_addr_wr = ex_operand[MDATAW-1:0];
	assign addr_out    = ex_operand[NBIOOU-1:0];
	assign mem_data_wr = acc;

endmodule

// File: stack_core_properties.sv
// --------------------------------------------------
// Stack core properties
// Strobe rules checked on the top level
// --------------------------------------------------

`timescale 1ns/1ps

module stack_core_properties
	import core_cfg_pkg::*;
(
	input logic  clk,
	input logic  rst,
	input logic  mem_wr,
	input logic  out_en,
	input logic  req_in,
	input data_t io_in,
	input data_t mem_data_wr
);

	// Store and output share the write data bus
	wr_out_excl: assert property (@(posedge clk) disable iff (rst) !(mem_wr && out_en))
		else $error("mem_wr and out_en are high in the same cycle");

	rst_quiet: assert property (@(posedge clk) rst |-> !mem_wr && !out_en && !req_in)
		else $error("A strobe is high during reset");

	// Input value reaches the accumulator two cycles after its request
	req_to_acc: assert property (@(posedge clk) disable iff (rst)
		req_in |-> ##2 (mem_data_wr == $past(io_in, 2)))
		else $error("Input value requested by req_in did not reach the accumulator");

endmodule

bind stack_core stack_core_properties stack_core_properties_i (
	.clk        (clk),
	.rst        (rst),
	.mem_wr     (mem_wr),
	.out_en     (out_en),
	.req_in     (req_in),
	.io_in      (io_in),
	.mem_data_wr(mem_data_wr)
);

// File: stack_core_tb.sv
// --------------------------------------------------
// Stack core testbench
// Program ROM, data memory and IO models, output checks
// --------------------------------------------------

`timescale 1ns/1ps

module stack_core_tb
	import core_cfg_pkg::*, isa_pkg::*;
();

	localparam int     CLK_HALF   = 10;
	localparam int     WAIT_LIMIT = 200;
	localparam int     NPROG      = 52;
	localparam int     NOUT       = 14;
	localparam int     DATA_BASE  = 16;
	localparam iaddr_t POISON     = 9'd41;
	localparam iaddr_t HALT       = 9'd44;

	typedef struct packed {
		iaddr_t addr;
		instr_t ins;
	} prog_entry_t;

	typedef struct packed {
		io_out_addr_t port;
		data_t        value;
	} out_entry_t;

	logic         clk;
	logic         rst;
	instr_t       instr;
	iaddr_t       instr_addr;
	logic         mem_wr;
	daddr_t       mem_addr_rd;
	daddr_t       mem_addr_wr;
	data_t        mem_data_wr;
	data_t        mem_data_rd;
	data_t        io_in;
	logic         req_in;
	io_in_addr_t  addr_in;
	logic         out_en;
	io_out_addr_t addr_out;

	instr_t      rom [2**MINSTW];
	data_t       dmem [2**MDATAW];
	data_t       dmem_tab [7];
	data_t       in_tab [4];
	prog_entry_t prog_tab [NPROG];
	out_entry_t  exp_tab [NOUT];

	stack_core stack_core_i (
		.clk        (clk),
		.rst        (rst),
		.instr      (instr),
		.instr_addr (instr_addr),
		.mem_wr     (mem_wr),
		.mem_addr_rd(mem_addr_rd),
		.mem_addr_wr(mem_addr_wr),
		.mem_data_wr(mem_data_wr),
		.mem_data_rd(mem_data_rd),
		.io_in      (io_in),
		.req_in     (req_in),
		.addr_in    (addr_in),
		.out_en     (out_en),
		.addr_out   (addr_out)
	);

	function automatic prog_entry_t place(int addr, opcode_t op, int arg);
		return {iaddr_t'(addr), op, operand_t'(arg)};
	endfunction

	function automatic out_entry_t expect_out(int port, data_t value);
		return {io_out_addr_t'(port), value};
	endfunction

	task automatic abort_run(input string msg);
		$display("%s", msg);
		$display("=== FAIL ===");
		$fatal(1, "Stopped at the first error");
	endtask

	task automatic check_data(input string name, input data_t got, input data_t exp);
		if (got !== exp)
			abort_run($sformatf("Error at %0t: %s is %h, expected %h", $time, name, got, exp));
	endtask

	task automatic check_out_addr(input string name, input io_out_addr_t got,
			input io_out_addr_t exp);
		if (got !== exp)
			abort_run($sformatf("Error at %0t: %s is %h, expected %h", $time, name, got, exp));
	endtask

	task automatic check_iaddr(input string name, input iaddr_t got, input iaddr_t exp);
		if (got !== exp)
			abort_run($sformatf("Error at %0t: %s is %h, expected %h", $time, name, got, exp));
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp)
			abort_run($sformatf("Error at %0t: %s is %b, expected %b", $time, name, got, exp));
	endtask

	initial begin
		clk = 1'b0;
		forever #CLK_HALF clk = ~clk;
	end

	// Program ROM and input ports answer combinationally
	assign instr = rom[instr_addr];
	assign io_in = req_in ? in_tab[addr_in] : '0;

	// Data memory with synchronous read
	always @(posedge clk) begin
		mem_data_rd <= dmem[mem_addr_rd];
		if (mem_wr)
			dmem[mem_addr_wr] <= mem_data_wr;
	end

	always @(negedge clk) begin
		if (!rst && instr_addr == POISON)
			abort_run("Fetched the poison address, a jump went to the wrong place");
	end

	initial begin
		int n;
		rst         = 1'b1;
		mem_data_rd = '0;
		// Words at addresses 16 to 22
		dmem_tab = '{16'sd100, 16'sd25, 16'sh00f0, 16'sh0ff0, 16'sh7777, 16'sd5, 16'sd0};
		in_tab   = '{16'sh1234, -16'sd300, 16'sh00c5, 16'sh7e01};
		prog_tab = '{
			place(0, OP_NOP, 0), place(1, OP_LOD, 16), place(2, OP_OUT, 0),
			place(3, OP_ADD, 17), place(4, OP_SUB, 21), place(5, OP_OUT, 1),
			place(6, OP_AND, 18), place(7, OP_XOR, 19), place(8, OP_OUT, 2),
			place(9, OP_SET, 20), place(10, OP_LOD, 16), place(11, OP_LOD, 20),
			place(12, OP_OUT, 3),
			// Data stack
			place(13, OP_LOD, 21), place(14, OP_PSH, 0), place(15, OP_LOD, 17),
			place(16, OP_PSH, 0), place(17, OP_LOD, 16), place(18, OP_PSH, 0),
			place(19, OP_POP, 0), place(20, OP_OUT, 0), place(21, OP_POP, 0),
			place(22, OP_OUT, 1), place(23, OP_SADD, 0), place(24, OP_OUT, 2),
			place(25, OP_PSH, 0), place(26, OP_LOD, 17), place(27, OP_SADD, 0),
			place(28, OP_OUT, 3),
			// Input ports
			place(29, OP_INN, 1), place(30, OP_OUT, 1), place(31, OP_INN, 2),
			place(32, OP_OUT, 3),
			// Taken JIZ skips 35 and 36, untaken JIZ and JMP pass over 41
			place(33, OP_LOD, 22), place(34, OP_JIZ, 37), place(35, OP_LOD, 16),
			place(36, OP_OUT, 0), place(37, OP_LOD, 16), place(38, OP_JIZ, 41),
			place(39, OP_OUT, 2), place(40, OP_JMP, 42), place(41, OP_OUT, 3),
			place(42, OP_CAL, 50), place(43, OP_OUT, 1), place(44, OP_JMP, 44),
			// Nested subroutines
			place(50, OP_ADD, 17), place(51, OP_CAL, 60), place(52, OP_OUT, 0),
			place(53, OP_RET, 0), place(60, OP_SUB, 21), place(61, OP_OUT, 2),
			place(62, OP_RET, 0)
		};
		exp_tab = '{
			expect_out(0, 16'sd100),
			expect_out(1, 16'sd100 + 16'sd25 - 16'sd5),
			expect_out(2, (16'sd120 & 16'sh00f0) ^ 16'sh0ff0),
			expect_out(3, (16'sd120 & 16'sh00f0) ^ 16'sh0ff0),
			expect_out(0, 16'sd100),
			expect_out(1, 16'sd25),
			expect_out(2, 16'sd25 + 16'sd5),
			expect_out(3, 16'sd30 + 16'sd25),
			expect_out(1, in_tab[1]),
			expect_out(3, in_tab[2]),
			expect_out(2, 16'sd100),
			expect_out(2, 16'sd100 + 16'sd25 - 16'sd5),
			expect_out(0, 16'sd120),
			expect_out(1, 16'sd120)
		};

		// Unused code jumps to itself, unused data follows the address
		for (int a = 0; a < 2**MINSTW; a++)
			rom[a] = {OP_JMP, operand_t'(a)};
		for (int a = 0; a < 2**MDATAW; a++)
			dmem[a] = data_t'(a) ^ 16'sh5a00;
		foreach (prog_tab[i])
			rom[prog_tab[i].addr] = prog_tab[i].ins;
		foreach (dmem_tab[i])
			dmem[DATA_BASE + i] = dmem_tab[i];

		//--------------------------------------------------
		// Reset
		//--------------------------------------------------
		repeat (10) begin
			@(negedge clk);
			check_bit("mem_wr", mem_wr, 1'b0);
			check_bit("out_en", out_en, 1'b0);
			check_bit("req_in", req_in, 1'b0);
			check_iaddr("instr_addr", instr_addr, '0);
		end
		@(posedge clk);
		rst <= 1'b0;
		@(negedge clk);
		check_bit("mem_wr", mem_wr, 1'b0);
		check_bit("out_en", out_en, 1'b0);
		check_bit("req_in", req_in, 1'b0);
		check_iaddr("instr_addr", instr_addr, '0);

		//--------------------------------------------------
		// Outputs in program order
		//--------------------------------------------------
		foreach (exp_tab[i]) begin
			n = 0;
			while (!out_en && n < WAIT_LIMIT) begin
				@(negedge clk);
				n++;
			end
			if (!out_en)
				abort_run($sformatf("Timed out waiting for out_en, output %0d of %0d", i, NOUT));
			check_out_addr("addr_out", addr_out, exp_tab[i].port);
			check_data("mem_data_wr", mem_data_wr, exp_tab[i].value);
			@(negedge clk);
		end

		// Program ends in its halt loop with no further output
		n = 0;
		while (instr_addr != HALT && n < WAIT_LIMIT) begin
			@(negedge clk);
			n++;
		end
		check_iaddr("instr_addr", instr_addr, HALT);
		repeat (4) begin
			@(negedge clk);
			check_bit("out_en", out_en, 1'b0);
		end

		$display("=== PASS ===");
		$finish;
	end

endmodule

// File: stack_core.f
core_cfg_pkg.sv
isa_pkg.sv
lifo.sv
instr_fetch.sv
instr_dec.sv
exec_unit.sv
stack_core.sv
stack_core_properties.sv
stack_core_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build the stack core testbench with Verilator, run it and check the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert --top-module stack_core_tb -f stack_core.f \
	&& ./obj_dir/Vstack_core_tb > sim.log 2>&1
cat sim.log 2>/dev/null

grep -q "^=== PASS ===$" sim.log \
	&& echo "Simulation passed" \
	|| { echo "Simulation failed"; exit 1; }
